//--- flist.f
+incdir+src
src/mdu_pkg.sv
src/mdu_div_req.sv
src/mdu_div_iter.sv
src/mdu_div_resp.sv
src/mdu_div_top.sv
dv/mdu_div_asserts.sv
dv/mdu_div_tb.sv

//--- Makefile
# Verilator build and run of the divide unit testbench
# Any variable can be overridden on the command line, e.g. make TOP=mdu_div_tb

VERILATOR  ?= verilator
TOP        ?= mdu_div_tb
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

# Default target builds and runs, exit status gives pass or fail
all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/mdu_div_stim.txt
// func rs1 rs2 expected, all hex
// func 0 DIV, 1 DIVU, 2 REM, 3 REMU
1 00000064 00000007 0000000e
3 00000064 00000007 00000002
1 00000005 00000009 00000000
3 00000005 00000009 00000005
1 deadbeef 00000001 deadbeef
3 deadbeef 00000001 00000000
1 ffffffff 00000010 0fffffff
3 ffffffff 00000010 0000000f
1 80000000 ffffffff 00000000
3 80000000 ffffffff 80000000
0 00000007 00000002 00000003
2 00000007 00000002 00000001
0 fffffff9 00000002 fffffffd
2 fffffff9 00000002 ffffffff
0 00000007 fffffffe fffffffd
2 00000007 fffffffe 00000001
0 fffffff9 fffffffe 00000003
2 fffffff9 fffffffe ffffffff
0 00001234 00000000 ffffffff
1 00001234 00000000 ffffffff
2 87654321 00000000 87654321
3 87654321 00000000 87654321
0 80000000 ffffffff 80000000
2 80000000 ffffffff 00000000

//--- dv/mdu_div_tb.sv
/*
 * Testbench for the integer divide unit. Runs the vectors from the stim
 * file, then seeded random vectors, checking result, latency and strobes.
 */
`default_nettype none

`include "mdu_cfg.svh"

module mdu_div_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import mdu_pkg::*;

    localparam int num_random = 40;

    logic     clk = 1'b0;
    logic     rstn;
    logic     req_valid;
    div_req_s req;
    logic     busy;
    logic     res_valid;
    xlen_t    res_data;

    // Vectors from the stim file
    div_func_t func_q[$];
    xlen_t     rs1_q[$];
    xlen_t     rs2_q[$];
    xlen_t     exp_q[$];

    int seed;
    int error_count  = 0;
    int sent_count   = 0;
    int strobe_count = 0;
    int cycle_count  = 0;
    int timeout_limit = 0;

    mdu_div_top mdu_div_top_inst (
        .clk       (clk),
        .rstn      (rstn),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Monitors
    ////////////////////////////////////////////////////////////////////////////

    // Every result strobe, spurious ones included
    always @(posedge clk) begin
        if (rstn && res_valid) begin
            strobe_count <= strobe_count + 1;
        end
    end

    // Run limit in cycles, armed once the vector count is known
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count > timeout_limit) begin
            $display("Errors found");
            $fatal(1, "simulation timed out waiting for a result");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h",
                     $time, name, got, exp);
            $display("Errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Expected word from the RISC-V M rules, zero divisor and overflow first
    function automatic xlen_t reference_result(input div_func_t f, input xlen_t a,
                                               input xlen_t b);
        logic want_rem;
        logic signed_op;
        int   sa;
        int   sb;
        want_rem  = f[1];
        signed_op = !f[0];
        sa = a;
        sb = b;
        if (b == 32'd0) begin
            return want_rem ? a : 32'hffff_ffff;
        end
        if (signed_op && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            return want_rem ? 32'd0 : 32'h8000_0000;
        end
        if (signed_op) begin
            return want_rem ? xlen_t'(sa % sb) : xlen_t'(sa / sb);
        end
        return want_rem ? a % b : a / b;
    endfunction

    task automatic load_vectors();
        int            fd;
        int            n;
        logic [8*160-1:0] line;
        logic [31:0]   f;
        logic [31:0]   a;
        logic [31:0]   b;
        logic [31:0]   e;
        fd = $fopen("dv/mdu_div_stim.txt", "r");
        if (fd == 0) begin
            $display("Errors found");
            $fatal(1, "cannot open the stimulus file dv/mdu_div_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                n = $fgets(line, fd);
                // Comment and blank lines do not scan as four hex fields
                if (n > 0 && $sscanf(line, "%h %h %h %h", f, a, b, e) == 4) begin
                    func_q.push_back(div_func_t'(f[1:0]));
                    rs1_q.push_back(a);
                    rs2_q.push_back(b);
                    exp_q.push_back(e);
                end
            end
            $fclose(fd);
        end
    endtask

    // One request, optionally with a second strobe sent while busy
    task automatic run_vector(input div_func_t f, input xlen_t a, input xlen_t b,
                              input xlen_t exp, input bit drop_test);
        int cycles;
        int want_cycles;
        // Zero divisor skips the compute loop
        want_cycles = (b == 32'd0) ? 3 : `MDU_DIV_CYCLES + 3;
        while (busy) begin
            @(posedge clk);
            #1;
        end
        req_valid = 1'b1;
        req.func  = f;
        req.rs1   = a;
        req.rs2   = b;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        sent_count++;
        cycles = 0;
        while (!res_valid) begin
            @(posedge clk);
            #1;
            cycles++;
            req_valid = 1'b0;
            if (drop_test && b != 32'd0 && cycles == 4) begin
                // Unit is busy, this strobe must vanish
                check_value("busy", {31'b0, busy}, 32'd1);
                // Other function and operands, so a strobe taken by mistake
                // changes res_data
                req_valid = 1'b1;
                req.func  = ~f;
                req.rs1   = ~a;
                req.rs2   = 32'd3;
            end
        end
        check_value("res_valid latency", cycles, want_cycles);
        check_value("res_data", res_data, exp);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        div_func_t   f;
        xlen_t       a;
        xlen_t       b;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        seed      = 32'h3b5a_aa42;

        load_vectors();
        if (func_q.size() == 0) begin
            $display("Errors found");
            $fatal(1, "stimulus file holds no vectors");
        end else begin
            timeout_limit = (func_q.size() + num_random) * 25 + 100;

            // Reset held for two cycles
            repeat (2) @(posedge clk);
            #1;
            rstn = 1'b1;

            // Directed vectors, the first one also carries the dropped strobe
            foreach (func_q[i]) begin
                run_vector(func_q[i], rs1_q[i], rs2_q[i], exp_q[i], i == 0);
            end

            // Idle window, no late result may show up
            repeat (25) @(posedge clk);
            #1;
            check_value("res_valid count", strobe_count, sent_count);

            // Random vectors, divisor width varied, sometimes zero
            for (int i = 0; i < num_random; i++) begin
                r = $random(seed);
                f = div_func_t'(r[1:0]);
                a = $random(seed);
                b = $random(seed);
                b = b >> r[6:2];
                if (r[11:8] == 4'd0) begin
                    b = 32'd0;
                end
                run_vector(f, a, b, reference_result(f, a, b), 1'b0);
            end

            repeat (3) @(posedge clk);
            #1;
            check_value("res_valid count", strobe_count, sent_count);

            if (error_count == 0) begin
                $display("No errors");
                $finish;
            end else begin
                $display("Errors found");
                $fatal(1, "%0d checks failed", error_count);
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/mdu_div_asserts.sv
/*
 * Concurrent checks on the divide unit's strobe and busy rules.
 * Bound into every mdu_div_top instance by the bind at the bottom.
 */
`default_nettype none

module mdu_div_asserts (
    input wire logic clk,
    input wire logic rstn,
    input wire logic busy,
    input wire logic res_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    // Result strobe lasts exactly one cycle
    res_valid_single: assert property (
        @(posedge clk) disable iff (!rstn) res_valid |=> !res_valid
    ) else $error("res_valid high for two cycles in a row");

    // A result only leaves inside the busy window
    res_valid_in_busy: assert property (
        @(posedge clk) disable iff (!rstn) res_valid |-> busy
    ) else $error("res_valid seen while busy is low");

    // First edge after reset release finds the unit idle
    busy_idle_after_reset: assert property (
        @(posedge clk) $rose(rstn) |-> !busy
    ) else $error("busy high right after reset release");

endmodule

bind mdu_div_top mdu_div_asserts mdu_div_asserts_inst (
    .clk       (clk),
    .rstn      (rstn),
    .busy      (busy),
    .res_valid (res_valid)
);

`default_nettype wire

//--- src/mdu_div_top.sv
/*
 * Top level of the integer divide unit.
 * Request strobe in, result strobe out, one division in flight.
 */
`default_nettype none

module mdu_div_top (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire logic                req_valid,
    input  wire mdu_pkg::div_req_s   req,
    output logic                     busy,
    output logic                     res_valid,
    output mdu_pkg::xlen_t           res_data
);
    import mdu_pkg::*;

    // Input side to divider
    logic      opnd_valid;
    div_opnd_s opnd;
    div_func_t func;

    // Divider and output side handshake
    logic      div_rdy;
    logic      div_done;
    div_res_s  res;

    ////////////////////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////////////////////

    mdu_div_req mdu_div_req_inst (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req        (req),
        .res_valid  (res_valid),
        .busy       (busy),
        .opnd_valid (opnd_valid),
        .opnd       (opnd),
        .func       (func)
    );

    mdu_div_iter mdu_div_iter_inst (
        .clk        (clk),
        .rstn       (rstn),
        .opnd_valid (opnd_valid),
        .opnd       (opnd),
        .div_done   (div_done),
        .div_rdy    (div_rdy),
        .res        (res)
    );

    mdu_div_resp mdu_div_resp_inst (
        .clk        (clk),
        .rstn       (rstn),
        .div_rdy    (div_rdy),
        .res        (res),
        .func       (func),
        .div_done   (div_done),
        .res_valid  (res_valid),
        .res_data   (res_data)
    );

endmodule

`default_nettype wire

//--- src/mdu_div_resp.sv
/*
 * Result side of the divide unit. Picks quotient or remainder,
 * drives the one-cycle result strobe and acknowledges the divider.
 */
`default_nettype none

module mdu_div_resp (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire logic                div_rdy,
    input  wire mdu_pkg::div_res_s   res,
    input  wire mdu_pkg::div_func_t  func,
    output logic                     div_done,
    output logic                     res_valid,
    output mdu_pkg::xlen_t           res_data
);
    import mdu_pkg::*;

    logic div_rdy_q;
    logic rdy_rise;
    logic sel_rem;

    // Exactly one strobe per result, even if div_rdy were to stretch
    assign rdy_rise = div_rdy && !div_rdy_q;

    // REM and REMU return the remainder
    assign sel_rem = (func == REM) || (func == REMU);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            div_rdy_q <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            div_rdy_q <= div_rdy;
            res_valid <= rdy_rise;
        end
    end

    // Result word, valid only alongside res_valid
    always_ff @(posedge clk) begin
        if (rdy_rise) begin
            res_data <= sel_rem ? res.remainder : res.quotient;
        end
    end

    // Divider released in the same cycle the result leaves the unit
    assign div_done = res_valid;

endmodule

`default_nettype wire

//--- src/mdu_div_iter.sv
/*
 * Iterative radix-4 divider with a four-state controller.
 * Works on magnitudes, two quotient bits per cycle, then fixes the signs.
 * Result holds with div_rdy until the output side returns div_done.
 */
`default_nettype none

`include "mdu_cfg.svh"

module mdu_div_iter (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire logic                opnd_valid,
    input  wire mdu_pkg::div_opnd_s  opnd,
    input  wire logic                div_done,
    output logic                     div_rdy,
    output mdu_pkg::div_res_s        res
);
    import mdu_pkg::*;

    localparam int cnt_w = $clog2(`MDU_DIV_CYCLES);
    localparam int sh_w  = $clog2(2 * `MDU_XLEN);
    localparam logic [cnt_w-1:0] last_cycle = cnt_w'(`MDU_DIV_CYCLES - 1);

    div_state_e                 state;
    div_state_e                 state_nxt;
    logic [cnt_w-1:0]           cycle;
    logic [cnt_w-1:0]           cycle_nxt;
    logic                       rdy_nxt;
    logic                       div_by_zero;

    // Operand magnitudes
    xlen_t                      src1;
    xlen_t                      src2;

    // Datapath of one step
    logic [sh_w-1:0]            shamt0;
    logic [sh_w-1:0]            shamt1;
    logic [2*`MDU_XLEN-1:0]     cmp0;
    logic [2*`MDU_XLEN-1:0]     cmp1;
    logic [`MDU_XLEN:0]         sub0;
    logic [`MDU_XLEN:0]         sub1;
    logic                       div0;
    logic                       div1;
    xlen_t                      rem0;
    xlen_t                      rem1;
    xlen_t                      rem2;

    // Two's complement magnitude of a sign-tagged operand
    function automatic xlen_t magnitude(input sxlen_t v);
        return v[`MDU_XLEN] ? xlen_t'(~v[`MDU_XLEN-1:0] + 1'b1) : v[`MDU_XLEN-1:0];
    endfunction

    assign div_by_zero = (opnd.divisor[`MDU_XLEN-1:0] == '0);

    ////////////////////////////////////////////////////////////////////////////
    // Radix-4 step
    ////////////////////////////////////////////////////////////////////////////

    // Divisor shifted to the bit pair worked on, top pair first
    assign shamt0 = sh_w'({last_cycle - cycle, 1'b0});
    assign shamt1 = shamt0 + 1'b1;
    assign cmp1   = {{`MDU_XLEN{1'b0}}, src2} << shamt1;
    assign cmp0   = {{`MDU_XLEN{1'b0}}, src2} << shamt0;

    // First step starts from the dividend magnitude
    assign rem2 = (cycle != '0) ? res.remainder : src1;

    // Upper quotient bit, no subtract if shifted divisor spills over
    assign sub1 = {1'b0, rem2} - {1'b0, cmp1[`MDU_XLEN-1:0]};
    assign div1 = (|cmp1[2*`MDU_XLEN-1:`MDU_XLEN]) ? 1'b0 : !sub1[`MDU_XLEN];
    assign rem1 = div1 ? sub1[`MDU_XLEN-1:0] : rem2;

    // Lower quotient bit from the partial remainder
    assign sub0 = {1'b0, rem1} - {1'b0, cmp0[`MDU_XLEN-1:0]};
    assign div0 = (|cmp0[2*`MDU_XLEN-1:`MDU_XLEN]) ? 1'b0 : !sub0[`MDU_XLEN];
    assign rem0 = div0 ? sub0[`MDU_XLEN-1:0] : rem1;

    ////////////////////////////////////////////////////////////////////////////
    // Controller
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        cycle_nxt = cycle;
        rdy_nxt   = 1'b0;
        case (state)
            WAIT_CMD: begin
                // Zero divisor goes straight to the fix-up state
                if (opnd_valid) begin
                    cycle_nxt = '0;
                    state_nxt = div_by_zero ? WAIT_DONE : WAIT_COMP;
                end
            end
            WAIT_COMP: begin
                cycle_nxt = cycle + 1'b1;
                if (cycle == last_cycle) begin
                    state_nxt = WAIT_DONE;
                end
            end
            WAIT_DONE: begin
                rdy_nxt   = 1'b1;
                state_nxt = WAIT_EXIT;
            end
            WAIT_EXIT: begin
                // Hold the result until the output side has taken it
                if (div_done) begin
                    state_nxt = WAIT_CMD;
                end
            end
            default: state_nxt = WAIT_CMD;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= WAIT_CMD;
            cycle   <= '0;
            div_rdy <= 1'b0;
        end else begin
            state   <= state_nxt;
            cycle   <= cycle_nxt;
            div_rdy <= rdy_nxt;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Operand and result registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        case (state)
            WAIT_CMD: begin
                if (opnd_valid) begin
                    src1 <= magnitude(opnd.dividend);
                    src2 <= magnitude(opnd.divisor);
                end
            end
            WAIT_COMP: begin
                // Quotient bits shift in from the bottom, MSB pair first
                res.quotient  <= {res.quotient[`MDU_XLEN-3:0], div1, div0};
                res.remainder <= rem0;
            end
            WAIT_DONE: begin
                if (div_by_zero) begin
                    res.quotient  <= '1;
                    res.remainder <= opnd.dividend[`MDU_XLEN-1:0];
                end else begin
                    // Quotient negative when operand signs differ
                    if (opnd.dividend[`MDU_XLEN] ^ opnd.divisor[`MDU_XLEN]) begin
                        res.quotient <= ~res.quotient + 1'b1;
                    end
                    // Remainder follows the dividend sign
                    if (opnd.dividend[`MDU_XLEN]) begin
                        res.remainder <= ~res.remainder + 1'b1;
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- src/mdu_div_req.sv
/*
 * Request capture for the divide unit. Accepts one strobe while idle,
 * builds the 33-bit operands and holds busy until the result strobe.
 */
`default_nettype none

module mdu_div_req (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire logic                req_valid,
    input  wire mdu_pkg::div_req_s   req,
    input  wire logic                res_valid,
    output logic                     busy,
    output logic                     opnd_valid,
    output mdu_pkg::div_opnd_s       opnd,
    output mdu_pkg::div_func_t       func
);
    import mdu_pkg::*;

    logic accept;
    logic is_signed;

    // A strobe during a running division is dropped
    assign accept = req_valid && !busy;

    // DIV and REM work on two's complement operands
    assign is_signed = (req.func == DIV) || (req.func == REM);

    ////////////////////////////////////////////////////////////////////////////
    // Control flags
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy       <= 1'b0;
            opnd_valid <= 1'b0;
        end else begin
            // One-cycle start pulse to the divider
            opnd_valid <= accept;
            // Busy window runs from acceptance up to the result strobe
            if (accept) begin
                busy <= 1'b1;
            end else if (res_valid) begin
                busy <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Operand capture
    ////////////////////////////////////////////////////////////////////////////

    // Held until the next accepted request, divider reads it freely
    always_ff @(posedge clk) begin
        if (accept) begin
            func <= req.func;
            // Sign bit copied into the tag for signed, zero otherwise
            opnd.dividend <= {is_signed & req.rs1[$bits(xlen_t)-1], req.rs1};
            opnd.divisor  <= {is_signed & req.rs2[$bits(xlen_t)-1], req.rs2};
        end
    end

endmodule

`default_nettype wire

//--- src/mdu_pkg.sv
/*
 * Shared types of the integer divide unit: widths, function codes,
 * the structs passed between blocks and the divider controller states.
 */
`default_nettype none

`include "mdu_cfg.svh"

package mdu_pkg;

    // Operand or result word
    typedef logic [`MDU_XLEN-1:0] xlen_t;

    // Operand with a sign tag on top, set for a negative value
    typedef logic [`MDU_XLEN:0] sxlen_t;

    // Function code, bit 1 picks remainder, bit 0 picks unsigned
    typedef logic [1:0] div_func_t;

    localparam div_func_t DIV  = 2'd0;
    localparam div_func_t DIVU = 2'd1;
    localparam div_func_t REM  = 2'd2;
    localparam div_func_t REMU = 2'd3;

    // Request as seen at the unit boundary
    typedef struct packed {
        div_func_t func;
        xlen_t     rs1;
        xlen_t     rs2;
    } div_req_s;

    // Sign-tagged operands handed to the divider
    typedef struct packed {
        sxlen_t dividend;
        sxlen_t divisor;
    } div_opnd_s;

    // Sign-corrected divider result
    typedef struct packed {
        xlen_t quotient;
        xlen_t remainder;
    } div_res_s;

    // Divider controller
    typedef enum logic [1:0] {
        WAIT_CMD,
        WAIT_COMP,
        WAIT_DONE,
        WAIT_EXIT
    } div_state_e;

endpackage

`default_nettype wire

//--- src/mdu_cfg.svh
/*
 * Build constants for the integer divide unit.
 * Include wherever the data width or the divider step count is needed.
 */
`ifndef MDU_CFG_SVH
`define MDU_CFG_SVH

// Operand and result width, fixed by the divider step arithmetic
`define MDU_XLEN 32

// Compute cycles in the divider, two quotient bits per cycle
`define MDU_DIV_CYCLES 16

`endif
